/* Makefile */
# Verilator build and run of the calculator testbench

VERILATOR ?= verilator
TOP       ?= calc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TB PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* calc_control.sv */
`timescale 1ns/1ps

module calc_control (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  key_pending_i,
    input  calc_keys_pkg::key_class_e             key_class_i,
    input  logic [calc_keys_pkg::KEY_W-1:0]        key_code_i,
    output logic                                  key_take_o,
    output logic                                  wr_en_o,
    output logic                                  wr_sel_result_o,
    output logic [calc_store_pkg::REG_ADDR_W-1:0] wr_addr_o,
    output logic [calc_store_pkg::REG_ADDR_W-1:0] rd_addr_a_o,
    output logic [calc_store_pkg::REG_ADDR_W-1:0] rd_addr_b_o,
    output logic [calc_store_pkg::REG_ADDR_W-1:0] disp_addr_o,
    output calc_keys_pkg::alu_op_e                alu_op_o,
    output logic                                  show_o,
    output logic                                  err_o
);
    import calc_keys_pkg::*;
    import calc_store_pkg::*;

    typedef enum logic [3:0] {
        WAIT_A, STORE_A, SHOW_A,
        WAIT_OP, SHOW_OP,
        WAIT_B, STORE_B, SHOW_B,
        WAIT_ENT, STORE_RES, SHOW_RES,
        NEXT,
        ERR_A, ERR_OP, ERR_B, ERR_ENT
    } ctrl_state_e;

    ctrl_state_e           state_q;
    ctrl_state_e           state_d;
    logic [REG_ADDR_W-1:0] base_q;
    logic [REG_ADDR_W-1:0] addr_b;
    logic [REG_ADDR_W-1:0] addr_res;
    alu_op_e               op_q;

    assign addr_b   = base_q + 5'd1;
    assign addr_res = base_q + 5'd2;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WAIT_A: begin
                if (key_pending_i) begin
                    state_d = (key_class_i == KEY_DIGIT) ? STORE_A : ERR_A;
                end
            end
            STORE_A:   state_d = SHOW_A;
            SHOW_A:    state_d = WAIT_OP;
            WAIT_OP: begin
                if (key_pending_i) begin
                    state_d = (key_class_i == KEY_OP) ? SHOW_OP : ERR_OP;
                end
            end
            SHOW_OP:   state_d = WAIT_B;
            WAIT_B: begin
                if (key_pending_i) begin
                    state_d = (key_class_i == KEY_DIGIT) ? STORE_B : ERR_B;
                end
            end
            STORE_B:   state_d = SHOW_B;
            SHOW_B:    state_d = WAIT_ENT;
            WAIT_ENT: begin
                if (key_pending_i) begin
                    state_d = (key_class_i == KEY_ENTER) ? STORE_RES : ERR_ENT;
                end
            end
            STORE_RES: state_d = SHOW_RES;
            SHOW_RES:  state_d = NEXT;
            NEXT:      state_d = WAIT_A;
            // wrong key, retry the same step
            ERR_A:     state_d = WAIT_A;
            ERR_OP:    state_d = WAIT_OP;
            ERR_B:     state_d = WAIT_B;
            ERR_ENT:   state_d = WAIT_ENT;
            default:   state_d = WAIT_A;
        endcase
    end

    always_comb begin
        key_take_o      = 1'b0;
        wr_en_o         = 1'b0;
        wr_sel_result_o = 1'b0;
        wr_addr_o       = base_q;
        disp_addr_o     = base_q;
        show_o          = 1'b0;
        err_o           = 1'b0;
        case (state_q)
            WAIT_A, WAIT_OP, WAIT_B, WAIT_ENT: key_take_o = key_pending_i;
            STORE_A: wr_en_o = 1'b1;
            // op key redisplays operand 1, clearing any error
            SHOW_A, SHOW_OP: show_o = 1'b1;
            STORE_B: begin
                wr_en_o   = 1'b1;
                wr_addr_o = addr_b;
            end
            SHOW_B: begin
                show_o      = 1'b1;
                disp_addr_o = addr_b;
            end
            STORE_RES: begin
                wr_en_o         = 1'b1;
                wr_sel_result_o = 1'b1;
                wr_addr_o       = addr_res;
            end
            SHOW_RES: begin
                show_o      = 1'b1;
                disp_addr_o = addr_res;
            end
            ERR_A, ERR_OP, ERR_B, ERR_ENT: err_o = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            state_q <= WAIT_A;
            base_q  <= FIRST_BASE;
            op_q    <= OP_ADD;
        end else begin
            state_q <= state_d;
            if (state_q == WAIT_OP && key_pending_i && key_class_i == KEY_OP) begin
                op_q <= alu_op_e'(key_code_i);
            end
            if (state_q == NEXT) begin
                base_q <= (base_q == LAST_BASE) ? FIRST_BASE : base_q + TRIPLE_STRIDE;
            end
        end
    end

    assign rd_addr_a_o = base_q;
    assign rd_addr_b_o = addr_b;
    assign alu_op_o    = op_q;

    a_show_err_excl: assert property (
        @(posedge clk_i) disable iff (reset_i) !(show_o && err_o)
    );

    // a write never uses the key being taken in the same cycle
    a_no_write_on_take: assert property (
        @(posedge clk_i) disable iff (reset_i) !(wr_en_o && key_take_o)
    );

endmodule

/* calc_datapath.sv */
`timescale 1ns/1ps

module calc_datapath #(
    parameter int DATA_W = 8
) (
    input  logic                                  clk_i,
    input  logic                                  reset_i,
    input  logic                                  wr_en_i,
    input  logic                                  wr_sel_result_i,
    input  logic [calc_store_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [calc_store_pkg::REG_ADDR_W-1:0] rd_addr_a_i,
    input  logic [calc_store_pkg::REG_ADDR_W-1:0] rd_addr_b_i,
    input  logic [calc_store_pkg::REG_ADDR_W-1:0] disp_addr_i,
    input  calc_keys_pkg::alu_op_e                alu_op_i,
    input  logic [calc_keys_pkg::KEY_W-1:0]        key_digit_i,
    output logic [DATA_W-1:0]                     disp_data_o
);
    import calc_keys_pkg::*;
    import calc_store_pkg::*;

    logic [DATA_W-1:0] regs_q [REG_COUNT];
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;
    logic [DATA_W-1:0] wr_data;

    // three asynchronous read ports
    assign op_a        = regs_q[rd_addr_a_i];
    assign op_b        = regs_q[rd_addr_b_i];
    assign disp_data_o = regs_q[disp_addr_i];

    // results wrap at DATA_W bits
    always_comb begin
        case (alu_op_i)
            OP_ADD:  alu_res = op_a + op_b;
            OP_SUB:  alu_res = op_a - op_b;
            OP_AND:  alu_res = op_a & op_b;
            OP_OR:   alu_res = op_a | op_b;
            OP_XOR:  alu_res = op_a ^ op_b;
            default: alu_res = '0;
        endcase
    end

    assign wr_data = wr_sel_result_i ? alu_res : DATA_W'(key_digit_i);

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs_q[wr_addr_i] <= wr_data;
        end
    end

    // triples only ever cover registers 1 to 30
    a_wr_addr_range: assert property (
        @(posedge clk_i) disable iff (reset_i)
        wr_en_i |-> (wr_addr_i >= FIRST_BASE) && (wr_addr_i < LAST_BASE + TRIPLE_STRIDE)
    );

endmodule

/* calc_keys_pkg.sv */
package calc_keys_pkg;

    // keypad code width
    localparam int unsigned KEY_W = 4;

    // highest digit key, everything above is a command
    localparam logic [KEY_W-1:0] KEY_DIGIT_LAST = 4'h9;
    localparam logic [KEY_W-1:0] KEY_ENTER_CODE = 4'hF;

    // operation keys A to E, values match the key codes
    typedef enum logic [3:0] {
        OP_ADD = 4'hA,
        OP_SUB = 4'hB,
        OP_AND = 4'hC,
        OP_OR  = 4'hD,
        OP_XOR = 4'hE
    } alu_op_e;

    // what kind of key the user pressed
    typedef enum logic [1:0] {
        KEY_DIGIT = 2'd0,
        KEY_OP    = 2'd1,
        KEY_ENTER = 2'd2
    } key_class_e;

endpackage

/* calc_store_pkg.sv */
package calc_store_pkg;

    // register file geometry
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned REG_COUNT  = 2 ** REG_ADDR_W;

    // each calculation owns base, base+1 and base+2
    localparam logic [REG_ADDR_W-1:0] TRIPLE_STRIDE = 5'd3;

    // register 0 stays unused
    localparam logic [REG_ADDR_W-1:0] FIRST_BASE = 5'd1;

    // last triple is 28..30, then back to the first one
    localparam logic [REG_ADDR_W-1:0] LAST_BASE = 5'd28;

endpackage

/* calc_tb.sv */
`timescale 1ns/1ps

module calc_tb;

    localparam int DATA_W         = 8;
    localparam int N_CALC         = 25;
    // each step sees at most one wrong key before the right one
    localparam int MAX_KEYS       = N_CALC * 8;
    localparam int TIMEOUT_CYCLES = 40 * MAX_KEYS;

    localparam int STEP_A   = 0;
    localparam int STEP_OP  = 1;
    localparam int STEP_B   = 2;
    localparam int STEP_ENT = 3;

    localparam logic [3:0] ENTER_CODE = 4'hF;

    logic              clk_i;
    logic              reset_i;
    logic [3:0]        key_code_i;
    logic              key_strobe_i;
    logic              ready_o;
    logic [DATA_W-1:0] disp_value_o;
    logic              disp_update_o;
    logic              disp_error_o;

    logic [31:0]       rng_state = 32'h76180fb2;
    int                cycle_count = 0;

    // reference state of the calculator
    logic [7:0]        model_a;
    logic [7:0]        model_b;
    logic [3:0]        model_op;
    logic [7:0]        model_value;
    logic              model_error;

    calc_top #(
        .DATA_W (DATA_W)
    ) dut_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .key_code_i    (key_code_i),
        .key_strobe_i  (key_strobe_i),
        .ready_o       (ready_o),
        .disp_value_o  (disp_value_o),
        .disp_update_o (disp_update_o),
        .disp_error_o  (disp_error_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $fatal(1, "run aborted by the cycle limit");
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(input int unsigned range, output int unsigned val);
        rng_state = lcg_step(rng_state);
        val = (rng_state >> 16) % range;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // wraps modulo 256 through the 8-bit operands
    function automatic logic [7:0] alu_model(input logic [3:0] op, input logic [7:0] a,
                                             input logic [7:0] b);
        case (op)
            4'hA:    return a + b;
            4'hB:    return a - b;
            4'hC:    return a & b;
            4'hD:    return a | b;
            4'hE:    return a ^ b;
            default: return 8'h00;
        endcase
    endfunction

    task automatic press_key(input logic [3:0] code, input bit inject);
        int unsigned junk;
        @(negedge clk_i);
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        key_code_i   <= code;
        key_strobe_i <= 1'b1;
        @(posedge clk_i);
        if (inject) begin
            // strobe held for one more edge while the buffer is full
            draw_random(16, junk);
            key_code_i <= 4'(junk);
            @(negedge clk_i);
            check_value("ready_o", 32'(ready_o), 32'h0);
            @(posedge clk_i);
        end
        key_strobe_i <= 1'b0;
    endtask

    task automatic wait_update();
        @(negedge clk_i);
        while (disp_update_o !== 1'b1) begin
            @(negedge clk_i);
        end
        // update is a single-cycle pulse
        @(negedge clk_i);
        check_value("disp_update_o", 32'(disp_update_o), 32'h0);
    endtask

    task automatic compare_display();
        check_value("disp_value_o", 32'(disp_value_o), 32'(model_value));
        check_value("disp_error_o", 32'(disp_error_o), 32'(model_error));
    endtask

    task automatic pick_invalid(input int step, output logic [3:0] bad);
        int unsigned r;
        case (step)
            STEP_OP: begin
                draw_random(11, r);
                bad = (r < 10) ? 4'(r) : ENTER_CODE;
            end
            STEP_ENT: begin
                draw_random(15, r);
                bad = 4'(r);
            end
            default: begin
                // any key from A to F is wrong where a digit is expected
                draw_random(6, r);
                bad = 4'hA + 4'(r);
            end
        endcase
    endtask

    task automatic run_step(input int step, input logic [3:0] code, input bit inject);
        int unsigned roll;
        logic [3:0]  bad;
        draw_random(4, roll);
        if (roll == 0) begin
            pick_invalid(step, bad);
            press_key(bad, 1'b0);
            wait_update();
            model_error = 1'b1;
            compare_display();
        end
        press_key(code, inject);
        wait_update();
        case (step)
            STEP_A: begin
                model_a     = {4'h0, code};
                model_value = model_a;
            end
            // op key shows operand 1 again
            STEP_OP: begin
                model_op    = code;
                model_value = model_a;
            end
            STEP_B: begin
                model_b     = {4'h0, code};
                model_value = model_b;
            end
            default: model_value = alu_model(model_op, model_a, model_b);
        endcase
        model_error = 1'b0;
        compare_display();
    endtask

    initial begin
        int unsigned inject_step;
        int unsigned digit_a;
        int unsigned digit_b;
        int unsigned op_idx;
        reset_i      = 1'b1;
        key_code_i   = 4'h0;
        key_strobe_i = 1'b0;
        model_a      = 8'h00;
        model_b      = 8'h00;
        model_op     = 4'hA;
        model_value  = 8'h00;
        model_error  = 1'b0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("disp_value_o", 32'(disp_value_o), 32'h0);
        check_value("disp_error_o", 32'(disp_error_o), 32'h0);
        check_value("disp_update_o", 32'(disp_update_o), 32'h0);
        check_value("ready_o", 32'(ready_o), 32'h1);

        // 25 calculations pass the triple wrap twice
        for (int calc = 0; calc < N_CALC; calc++) begin
            draw_random(4, inject_step);
            draw_random(10, digit_a);
            draw_random(5, op_idx);
            draw_random(10, digit_b);
            run_step(STEP_A, 4'(digit_a), inject_step == STEP_A);
            run_step(STEP_OP, 4'hA + 4'(op_idx), inject_step == STEP_OP);
            run_step(STEP_B, 4'(digit_b), inject_step == STEP_B);
            run_step(STEP_ENT, ENTER_CODE, inject_step == STEP_ENT);
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

/* calc_top.sv */
`timescale 1ns/1ps

module calc_top #(
    parameter int DATA_W = 8
) (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [calc_keys_pkg::KEY_W-1:0] key_code_i,
    input  logic                           key_strobe_i,
    output logic                           ready_o,
    output logic [DATA_W-1:0]              disp_value_o,
    output logic                           disp_update_o,
    output logic                           disp_error_o
);
    import calc_keys_pkg::*;
    import calc_store_pkg::*;

    logic                  key_pending;
    logic [KEY_W-1:0]      key_code;
    key_class_e            key_class;
    logic                  key_take;
    logic                  wr_en;
    logic                  wr_sel_result;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [REG_ADDR_W-1:0] rd_addr_a;
    logic [REG_ADDR_W-1:0] rd_addr_b;
    logic [REG_ADDR_W-1:0] disp_addr;
    alu_op_e               alu_op;
    logic                  show;
    logic                  err;
    logic [DATA_W-1:0]     disp_data;

    // one-deep key buffer is the only back-pressure
    assign ready_o = ~key_pending;

    keypad_capture capture_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .key_code_i    (key_code_i),
        .key_strobe_i  (key_strobe_i),
        .key_take_i    (key_take),
        .key_pending_o (key_pending),
        .key_code_o    (key_code),
        .key_class_o   (key_class)
    );

    calc_control control_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .key_pending_i   (key_pending),
        .key_class_i     (key_class),
        .key_code_i      (key_code),
        .key_take_o      (key_take),
        .wr_en_o         (wr_en),
        .wr_sel_result_o (wr_sel_result),
        .wr_addr_o       (wr_addr),
        .rd_addr_a_o     (rd_addr_a),
        .rd_addr_b_o     (rd_addr_b),
        .disp_addr_o     (disp_addr),
        .alu_op_o        (alu_op),
        .show_o          (show),
        .err_o           (err)
    );

    calc_datapath #(
        .DATA_W (DATA_W)
    ) datapath_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .wr_en_i         (wr_en),
        .wr_sel_result_i (wr_sel_result),
        .wr_addr_i       (wr_addr),
        .rd_addr_a_i     (rd_addr_a),
        .rd_addr_b_i     (rd_addr_b),
        .disp_addr_i     (disp_addr),
        .alu_op_i        (alu_op),
        .key_digit_i     (key_code),
        .disp_data_o     (disp_data)
    );

    display_latch #(
        .DATA_W (DATA_W)
    ) display_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .show_i        (show),
        .err_i         (err),
        .disp_data_i   (disp_data),
        .disp_value_o  (disp_value_o),
        .disp_update_o (disp_update_o),
        .disp_error_o  (disp_error_o)
    );

endmodule

/* compile.f */
calc_keys_pkg.sv
calc_store_pkg.sv
keypad_capture.sv
calc_control.sv
calc_datapath.sv
display_latch.sv
calc_top.sv
calc_tb.sv

/* display_latch.sv */
`timescale 1ns/1ps

module display_latch #(
    parameter int DATA_W = 8
) (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic              show_i,
    input  logic              err_i,
    input  logic [DATA_W-1:0] disp_data_i,
    output logic [DATA_W-1:0] disp_value_o,
    output logic              disp_update_o,
    output logic              disp_error_o
);

    logic [DATA_W-1:0] value_q;
    logic              error_q;
    logic              update_q;

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            value_q  <= '0;
            error_q  <= 1'b0;
            update_q <= 1'b0;
        end else begin
            // strobe lands together with the new value
            update_q <= show_i | err_i;
            if (show_i) begin
                value_q <= disp_data_i;
                error_q <= 1'b0;
            end else if (err_i) begin
                error_q <= 1'b1;
            end
        end
    end

    assign disp_value_o  = value_q;
    assign disp_update_o = update_q;
    assign disp_error_o  = error_q;

endmodule

/* keypad_capture.sv */
`timescale 1ns/1ps

module keypad_capture (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [calc_keys_pkg::KEY_W-1:0] key_code_i,
    input  logic                           key_strobe_i,
    input  logic                           key_take_i,
    output logic                           key_pending_o,
    output logic [calc_keys_pkg::KEY_W-1:0] key_code_o,
    output calc_keys_pkg::key_class_e      key_class_o
);
    import calc_keys_pkg::*;

    logic             pending_q;
    logic [KEY_W-1:0] code_q;
    key_class_e       class_q;
    key_class_e       class_d;

    // classify the raw code once, on the way in
    always_comb begin
        if (key_code_i <= KEY_DIGIT_LAST) begin
            class_d = KEY_DIGIT;
        end else if (key_code_i == KEY_ENTER_CODE) begin
            class_d = KEY_ENTER;
        end else begin
            class_d = KEY_OP;
        end
    end

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (key_strobe_i && !pending_q) begin
            pending_q <= 1'b1;
        end else if (key_take_i) begin
            pending_q <= 1'b0;
        end
    end

    // held until the next accepted strobe
    always_ff @(posedge clk_i) begin
        if (key_strobe_i && !pending_q) begin
            code_q  <= key_code_i;
            class_q <= class_d;
        end
    end

    assign key_pending_o = pending_q;
    assign key_code_o    = code_q;
    assign key_class_o   = class_q;

    // controller only consumes a key that is actually held
    a_take_while_pending: assert property (
        @(posedge clk_i) disable iff (reset_i) key_take_i |-> pending_q
    );

endmodule
